// ==== all.f ====
logic/cache_pkg.sv
logic/cache_data_array.sv
logic/cache_meta_array.sv
logic/cache_core.sv
logic/cache_fill_ctrl.sv
logic/cache_top.sv
tb/cache_tb.sv

// ==== logic/cache_core.sv ====
`timescale 1ns/1ps

module cache_core import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  addr_t     addr,           // Request address from the CPU
  input  logic      array_word_wr,  // Write one word into the data array
  input  logic      fill_active,    // Refill in progress, steer writes to the victim
  input  word_idx_t fill_word,      // Word of the line being refilled
  input  word_t     fill_data,      // Word coming back from memory
  input  word_t     wdata,          // CPU write data for a write hit
  input  logic      meta_wr,        // Install the tag once the line is complete
  input  logic      lru_touch,      // Mark the hit way as used
  output logic      hit,
  output logic      hit_way,
  output word_t     rdata           // Hit word, zero on a miss
);

  meta_t meta0;
  meta_t meta1;
  word_t way0_data;
  word_t way1_data;

  logic match0;
  logic match1;
  logic victim_way;  // Way to replace, from the current LRU bits
  logic victim_q;    // Victim frozen for the length of a refill

  word_idx_t arr_word;
  logic      arr_way;
  word_t     arr_wdata;

  //////////////////////////////
  // Tag compare
  //////////////////////////////
  // A way matches only if its line is valid and the tags agree
  assign match0 = meta0.valid && (meta0.tag == addr_tag(addr));
  assign match1 = meta1.valid && (meta1.tag == addr_tag(addr));

  assign hit     = match0 | match1;
  assign hit_way = match1;  // Way 1 wins the select, both can never match at once

  assign rdata = hit ? (match1 ? way1_data : way0_data) : '0;

  // Way 0 used last means way 1 goes next
  assign victim_way = meta0.lru;

  // Tracks the victim until a refill starts, then holds it
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= 1'b0;
    end else if (!fill_active) begin
      victim_q <= victim_way;
    end
  end

  //////////////////////////////
  // Write steering
  //////////////////////////////
  assign arr_word  = fill_active ? fill_word : addr_word(addr);
  assign arr_way   = fill_active ? victim_q  : hit_way;  // Refill goes to the victim
  assign arr_wdata = fill_active ? fill_data : wdata;

  cache_data_array u_data_array (
    .clk    (clk),
    .rst    (rst),
    .set    (addr_set(addr)),
    .word   (arr_word),
    .wr     (array_word_wr),
    .wr_way (arr_way),
    .wdata  (arr_wdata),
    .rdata0 (way0_data),
    .rdata1 (way1_data)
  );

  // The install targets the held victim, a touch targets the hit way
  cache_meta_array u_meta_array (
    .clk       (clk),
    .rst       (rst),
    .set       (addr_set(addr)),
    .wr        (meta_wr),
    .wr_way    (victim_q),
    .tag       (addr_tag(addr)),
    .touch     (lru_touch),
    .touch_way (hit_way),
    .meta0     (meta0),
    .meta1     (meta1)
  );

endmodule

// ==== logic/cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  set_idx_t  set,     // Set being looked at or written
  input  word_idx_t word,    // Word within the line
  input  logic      wr,      // Write strobe for one word
  input  logic      wr_way,  // Way that takes the write
  input  word_t     wdata,
  output word_t     rdata0,  // Word from way 0, combinational
  output word_t     rdata1   // Word from way 1, combinational
);

  //////////////////////////////
  // Storage
  //////////////////////////////
  // Each way is a flat array of 64 lines by 8 words, indexed by {set, word}
  word_t data_mem [NUM_WAYS][NUM_SETS*WORDS_PER_LINE];

  logic [SET_W+WORD_W-1:0] line_word;  // Flat word index within a way

  assign line_word = {set, word};

  // Both ways are read every cycle so the tag compare can pick one
  assign rdata0 = data_mem[0][line_word];
  assign rdata1 = data_mem[1][line_word];

  //////////////////////////////
  // Word write
  //////////////////////////////
  // Contents survive reset, only the write is held off while rst is high
  always_ff @(posedge clk) begin
    if (wr && !rst) begin
      data_mem[wr_way][line_word] <= wdata;
    end
  end

endmodule

// ==== logic/cache_fill_ctrl.sv ====
`timescale 1ns/1ps

module cache_fill_ctrl import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  cpu_req_t  cpu_req,
  input  logic      hit,            // Lookup result from the core
  input  word_t     rdata,          // Hit word from the core
  output logic      cpu_done,
  output word_t     cpu_rdata,
  output logic      cpu_hit,
  output logic      array_word_wr,
  output logic      fill_active,
  output word_idx_t fill_word,
  output word_t     fill_data,
  output logic      meta_wr,
  output logic      lru_touch,
  output logic      mem_rd,
  output logic      mem_wr,
  output addr_t     mem_addr,
  output word_t     mem_wdata,
  input  logic      mem_rvalid,
  input  word_t     mem_rdata,
  input  logic      mem_wack
);

  fill_state_t state;
  fill_state_t state_nxt;

  word_idx_t word_cnt;   // Next word of the line to fetch
  logic      refilled;   // Line was fetched, so the current lookup is the second one
  logic      last_word;  // Counter sits on the final word of the line
  logic      cpu_hit_q;
  word_t     rdata_q;

  assign last_word = (word_cnt == word_idx_t'(WORDS_PER_LINE - 1));

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////
  always_comb begin
    state_nxt     = state;
    array_word_wr = 1'b0;
    meta_wr       = 1'b0;
    lru_touch     = 1'b0;
    mem_rd        = 1'b0;
    mem_wr        = 1'b0;
    case (state)
      IDLE: begin
        if (cpu_req.rd || cpu_req.wr) state_nxt = LOOKUP;
      end
      LOOKUP: begin
        if (cpu_req.wr) begin
          mem_wr        = 1'b1;  // Write-through starts with the lookup
          array_word_wr = hit;   // Cache copy only updated on a hit
          lru_touch     = hit;
          state_nxt     = WRITE_MEM;
        end else if (hit) begin
          lru_touch = 1'b1;
          state_nxt = DONE;
        end else begin
          state_nxt = FILL_REQ;  // Read miss, fetch the whole line
        end
      end
      FILL_REQ: begin
        mem_rd    = 1'b1;  // One-cycle request pulse
        state_nxt = FILL_WAIT;
      end
      FILL_WAIT: begin
        if (mem_rvalid) begin
          array_word_wr = 1'b1;
          // The tag goes in with the eighth word, then look again
          if (last_word) begin
            meta_wr   = 1'b1;
            state_nxt = LOOKUP;
          end else begin
            state_nxt = FILL_REQ;
          end
        end
      end
      WRITE_MEM: begin
        if (mem_wack) state_nxt = DONE;
      end
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  assign fill_active = (state == FILL_REQ) || (state == FILL_WAIT);
  assign fill_word   = word_cnt;
  assign fill_data   = mem_rdata;  // Memory word goes straight into the array

  // Refill walks the line in order, everything else uses the CPU address
  assign mem_addr  = fill_active ? line_word_addr(cpu_req.addr, word_cnt) : cpu_req.addr;
  assign mem_wdata = cpu_req.wdata;

  //////////////////////////////
  // State and counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      word_cnt  <= '0;
      refilled  <= 1'b0;
      cpu_hit_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == IDLE) begin
        word_cnt <= '0;
        refilled <= 1'b0;
      end
      if (state == FILL_WAIT && mem_rvalid) begin
        word_cnt <= word_cnt + word_idx_t'(1);
        if (last_word) refilled <= 1'b1;
      end
      // Only the first lookup is reported to the CPU
      if (state == LOOKUP && !refilled) cpu_hit_q <= hit;
    end
  end

  // Read word held for the done cycle
  always_ff @(posedge clk) begin
    if (state == LOOKUP && hit) rdata_q <= rdata;
  end

  assign cpu_done  = (state == DONE);
  assign cpu_hit   = cpu_hit_q;
  assign cpu_rdata = rdata_q;

endmodule

// ==== logic/cache_meta_array.sv ====
`timescale 1ns/1ps

module cache_meta_array import cache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  set_idx_t set,        // Set addressed this cycle
  input  logic     wr,         // Install a new tag after a refill
  input  logic     wr_way,     // Way that takes the new tag
  input  tag_t     tag,        // Tag to install
  input  logic     touch,      // Mark a way as used on a hit
  input  logic     touch_way,  // Way that was hit
  output meta_t    meta0,      // Way 0 metadata, combinational
  output meta_t    meta1       // Way 1 metadata, combinational
);

  meta_t meta_mem [NUM_WAYS][NUM_SETS];

  logic mru_way;  // Way that becomes most recently used this cycle

  // An install always counts as a use of that way
  assign mru_way = wr ? wr_way : touch_way;

  assign meta0 = meta_mem[0][set];
  assign meta1 = meta_mem[1][set];

  //////////////////////////////
  // Tag install and LRU update
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      // Every line comes out of reset invalid with both LRU bits clear
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          meta_mem[w][s].valid <= 1'b0;
          meta_mem[w][s].lru   <= 1'b0;
        end
      end
    end else begin
      if (wr) begin
        meta_mem[wr_way][set].tag   <= tag;
        meta_mem[wr_way][set].valid <= 1'b1;  // Line is now filled
      end
      // The used way gets its lru bit, the other way loses it
      if (wr || touch) begin
        meta_mem[mru_way][set].lru  <= 1'b1;
        meta_mem[~mru_way][set].lru <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////
  localparam int ADDR_W = 16;  // Byte address from the CPU
  localparam int DATA_W = 16;  // One CPU word
  localparam int TAG_W  = 6;   // Address bits 15:10
  localparam int SET_W  = 6;   // Address bits 9:4
  localparam int WORD_W = 3;   // Address bits 3:1, bit 0 is a byte offset we never use

  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 64;
  localparam int WORDS_PER_LINE = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [SET_W-1:0]  set_idx_t;
  typedef logic [WORD_W-1:0] word_idx_t;

  // One metadata byte per way per set, laid out as tag, valid, lru from MSB down
  typedef struct packed {
    tag_t tag;
    logic valid;  // Line holds real data
    logic lru;    // Set when this way was the one used last in its set
  } meta_t;

  // CPU request, held as a level until cpu_done
  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t wdata;  // Only looked at for writes
  } cpu_req_t;

  // Fill controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_REQ,
    FILL_WAIT,
    WRITE_MEM,
    DONE
  } fill_state_t;

  //////////////////////////////
  // Address field helpers
  //////////////////////////////
  function automatic tag_t addr_tag(addr_t a);
    return a[15:10];
  endfunction

  function automatic set_idx_t addr_set(addr_t a);
    return a[9:4];
  endfunction

  function automatic word_idx_t addr_word(addr_t a);
    return a[3:1];
  endfunction

  // Byte address of word w inside the line that holds a
  function automatic addr_t line_word_addr(addr_t a, word_idx_t w);
    return {a[15:4], w, 1'b0};
  endfunction

endpackage

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t cpu_req,
  output logic     cpu_done,
  output word_t    cpu_rdata,
  output logic     cpu_hit,
  output logic     mem_rd,
  output logic     mem_wr,
  output addr_t    mem_addr,
  output word_t    mem_wdata,
  input  logic     mem_rvalid,
  input  word_t    mem_rdata,
  input  logic     mem_wack
);

  //////////////////////////////
  // Core to controller wires
  //////////////////////////////
  logic      hit;
  word_t     rdata;
  logic      array_word_wr;
  logic      fill_active;
  word_idx_t fill_word;
  word_t     fill_data;
  logic      meta_wr;
  logic      lru_touch;

  // The request address indexes the arrays directly, hit way stays inside the core
  cache_core u_cache_core (
    .clk           (clk),
    .rst           (rst),
    .addr          (cpu_req.addr),
    .array_word_wr (array_word_wr),
    .fill_active   (fill_active),
    .fill_word     (fill_word),
    .fill_data     (fill_data),
    .wdata         (cpu_req.wdata),
    .meta_wr       (meta_wr),
    .lru_touch     (lru_touch),
    .hit           (hit),
    .hit_way       (),
    .rdata         (rdata)
  );

  cache_fill_ctrl u_cache_fill_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .hit           (hit),
    .rdata         (rdata),
    .cpu_done      (cpu_done),
    .cpu_rdata     (cpu_rdata),
    .cpu_hit       (cpu_hit),
    .array_word_wr (array_word_wr),
    .fill_active   (fill_active),
    .fill_word     (fill_word),
    .fill_data     (fill_data),
    .meta_wr       (meta_wr),
    .lru_touch     (lru_touch),
    .mem_rd        (mem_rd),
    .mem_wr        (mem_wr),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rvalid    (mem_rvalid),
    .mem_rdata     (mem_rdata),
    .mem_wack      (mem_wack)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run from the project root, judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module cache_tb -f all.f -o cache_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0

// ==== tb/cache_stim.txt ====
# op addr wdata exp_rdata exp_hit, hex columns, op r for read and w for write
# Memory word at byte address a starts as (a >> 1) ^ 5a5a, writes go through to it
# Cold miss in set 1, then hits on the same line
r 0010 0000 5a52 0
r 001a 0000 5a57 1
r 001e 0000 5a55 1
# Three tags in set 2, the third evicts the least recently used line
r 0420 0000 584a 0
r 0820 0000 5e4a 0
r 0c20 0000 5c4a 0
r 0c26 0000 5c49 1
r 0822 0000 5e4b 1
r 0420 0000 584a 0
r 0824 0000 5e48 1
r 0c20 0000 5c4a 0
# Set 3 with A, B, A, then C evicts B
r 1030 0000 5242 0
r 1430 0000 5042 0
r 1038 0000 5246 1
r 1830 0000 5642 0
r 1030 0000 5242 1
r 1430 0000 5042 0
r 1830 0000 5642 0
# Set 4 write hit and write miss
r 1c44 0000 5478 0
w 1c44 beef 0000 1
r 1c44 0000 beef 1
r 1c46 0000 5479 1
w 2046 1234 0000 0
r 2046 0000 1234 0
r 2046 0000 1234 1
r 2040 0000 4a7a 1
r 1c44 0000 beef 1
w 2040 cafe 0000 1
r 2040 0000 cafe 1
# Evict both written lines, memory must hold the written words
r 2440 0000 487a 0
r 1c44 0000 beef 0
r 2040 0000 cafe 0
# Sets 5 and 6 side by side
r 2850 0000 4e72 0
r 2860 0000 4e6a 0
r 2c50 0000 4c72 0
r 2c60 0000 4c6a 0
r 3050 0000 4272 0
r 2860 0000 4e6a 1
r 2c60 0000 4c6a 1
r 2850 0000 4e72 0
r 0012 0000 5a53 1
r 2c50 0000 4c72 0
# Top of the address space, bit 0 of the address is ignored
r fffe 0000 25a5 0
r fff0 0000 25a2 1
w fff2 0f0f 0000 1
r fff3 0000 0f0f 1
r 0011 0000 5a52 1

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int MEM_WORDS       = 32768;  // Full 16-bit byte address space in words
  localparam int CYCLES_PER_LINE = 60;     // Budget for one access including a refill
  localparam int RESET_CYCLES    = 10;

  logic     clk;
  logic     rst;
  cpu_req_t cpu_req;
  logic     cpu_done;
  word_t    cpu_rdata;
  logic     cpu_hit;
  logic     mem_rd;
  logic     mem_wr;
  addr_t    mem_addr;
  word_t    mem_wdata;
  logic     mem_rvalid;
  word_t    mem_rdata;
  logic     mem_wack;

  word_t       mem_model [MEM_WORDS];  // Backing store behind the cache
  logic [14:0] rd_idx;                 // Word address of the read in flight
  int          rd_wait = 0;            // Cycles left until mem_rvalid or 0 when idle
  int          wr_wait = 0;            // Cycles left until mem_wack

  // One entry per stimulus line
  logic [7:0] op_q [$];
  addr_t      addr_q [$];
  word_t      wdata_q [$];
  word_t      exp_rdata_q [$];
  logic       exp_hit_q [$];

  int          cycle_cnt   = 0;
  int          cycle_limit = 0;  // Set once the stimulus is loaded

  cache_top u_cache_top (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .cpu_done   (cpu_done),
    .cpu_rdata  (cpu_rdata),
    .cpu_hit    (cpu_hit),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .mem_wack   (mem_wack)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic stop_with_error(string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run aborted");
  endtask

  // Hard limit on the run length sized from the number of accesses
  initial begin
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
        stop_with_error("Timed out waiting for the cache to finish an access");
      end
    end
  end

  //////////////////////////////
  // Memory model
  //////////////////////////////
  // Answers change on the falling edge where the DUT strobes are stable
  initial begin
    void'($urandom(32'h8658));  // Same latency sequence on every run
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = word_t'(i) ^ 16'h5A5A;  // Every word differs so a wrong fetch shows up
    end
    mem_rvalid = 1'b0;
    mem_wack   = 1'b0;
    mem_rdata  = '0;
    forever begin
      @(negedge clk);
      mem_rvalid = 1'b0;  // Answers are one-cycle pulses
      mem_wack   = 1'b0;
      if (rd_wait > 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          mem_rvalid = 1'b1;
          mem_rdata  = mem_model[rd_idx];
        end
      end
      if (wr_wait > 0) begin
        wr_wait--;
        if (wr_wait == 0) mem_wack = 1'b1;
      end
      if (mem_rd) begin
        if (rd_wait > 0) stop_with_error("Second memory read issued while one was outstanding");
        rd_idx  = mem_addr[15:1];
        rd_wait = 1 + int'($urandom % 4);  // 1 to 4 cycles of latency
      end
      if (mem_wr) begin
        mem_model[mem_addr[15:1]] = mem_wdata;  // Write-through lands right away
        wr_wait = 1 + int'($urandom % 4);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic load_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    addr_t      a;
    word_t      wd;
    word_t      rd;
    logic [15:0] h;
    fd = $fopen("tb/cache_stim.txt", "r");
    if (fd == 0) stop_with_error("Could not open tb/cache_stim.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) continue;
      if (line[0] == "#") continue;  // Column description
      n = $sscanf(line, "%s %h %h %h %h", op, a, wd, rd, h);
      if (n <= 0) continue;  // Blank line
      if (n != 5 || (op != "r" && op != "w")) begin
        stop_with_error("Malformed line in the stimulus file");
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      wdata_q.push_back(wd);
      exp_rdata_q.push_back(rd);
      exp_hit_q.push_back(h[0]);
    end
    $fclose(fd);
    if (op_q.size() == 0) stop_with_error("The stimulus file holds no accesses");
  endtask

  // Holds the request until cpu_done and then checks the response
  task automatic run_access(int idx);
    cpu_req_t req;
    req.rd    = (op_q[idx] == "r");
    req.wr    = (op_q[idx] == "w");
    req.addr  = addr_q[idx];
    req.wdata = wdata_q[idx];
    @(negedge clk);
    cpu_req = req;
    do @(negedge clk); while (!cpu_done);
    check_value("cpu_hit", 16'(exp_hit_q[idx]), 16'(cpu_hit));
    if (req.rd) check_value("cpu_rdata", exp_rdata_q[idx], cpu_rdata);
    cpu_req = '0;  // Drop the request after the done pulse
  endtask

  initial begin
    rst      = 1'b1;
    cpu_req  = '0;
    load_stimulus();
    cycle_limit = op_q.size() * CYCLES_PER_LINE + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      run_access(i);
    end
    @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
